/* Bender.yml */
package:
  name: siggen

sources:
  - verilog/siggen_regs_pkg.sv
  - verilog/siggen_stream_pkg.sv
  - verilog/sample_stream_if.sv
  - verilog/siggen_settings.sv
  - verilog/sine_tone.sv
  - verilog/const_source.sv
  - verilog/packet_framer.sv
  - verilog/siggen_top.sv
  - target: test
    files:
      - tests/tb_siggen.sv

/* tests/tb_siggen.sv */
////////////////////////////////////////
// Signal generator testbench
// Host setup, stream model and checks
////////////////////////////////////////
`timescale 1ns/100ps

module tb_siggen;

  // About 900 cycles of stimulus plus margin
  localparam int MAX_CYCLES = 3000;
  localparam int BUS_LIMIT  = 8;

  logic        ce_clk;
  logic        i_reset;
  logic        i_wb_cyc;
  logic        i_wb_stb;
  logic        i_wb_we;
  logic [3:0]  i_wb_adr;
  logic [31:0] i_wb_dat;
  logic [31:0] o_wb_dat;
  logic        o_wb_ack;
  logic [31:0] o_tdata;
  logic        o_tlast;
  logic        o_tvalid;
  logic        i_tready;

  // Expected stream state
  siggen_regs_pkg::wave_e exp_wave;
  logic [31:0] exp_amp;
  logic [31:0] exp_freq;
  logic [31:0] exp_phase;
  logic [15:0] exp_pkt;
  logic [15:0] exp_len;
  logic [15:0] exp_count;
  logic [31:0] exp_tdata;
  logic        exp_tlast;
  logic        idle_check;

  integer seed;
  int     errors = 0;
  int     hangs = 0;
  int     xfers = 0;
  int     cycles = 0;

  siggen_top UUT (
    .ce_clk   (ce_clk),
    .i_reset  (i_reset),
    .i_wb_cyc (i_wb_cyc),
    .i_wb_stb (i_wb_stb),
    .i_wb_we  (i_wb_we),
    .i_wb_adr (i_wb_adr),
    .i_wb_dat (i_wb_dat),
    .o_wb_dat (o_wb_dat),
    .o_wb_ack (o_wb_ack),
    .o_tdata  (o_tdata),
    .o_tlast  (o_tlast),
    .o_tvalid (o_tvalid),
    .i_tready (i_tready)
  );

  initial begin
    ce_clk = 1'b0;
    forever #20 ce_clk = ~ce_clk;
  end

  // {cos, sin} pair with the cosine a quarter turn ahead
  function automatic logic [31:0] tone_sample(input logic [31:0] ph);
    int idx;
    idx = ph >> 26;
    return {siggen_stream_pkg::SINE_TABLE[(idx + 16) % 64],
            siggen_stream_pkg::SINE_TABLE[idx]};
  endfunction

  assign exp_len   = (exp_pkt == 16'd0) ? 16'd1 : exp_pkt;
  assign exp_tlast = (exp_count == exp_len - 16'd1);
  assign exp_tdata = (exp_wave == siggen_regs_pkg::WAVE_SINE) ? tone_sample(exp_phase) : exp_amp;

  ////////////////////////////////////////
  // Model advances on observed transfers
  ////////////////////////////////////////
  always @(posedge ce_clk) begin
    if (!i_reset && o_tvalid && i_tready) begin
      xfers <= xfers + 1;
      if (exp_wave == siggen_regs_pkg::WAVE_SINE) begin
        exp_phase <= exp_phase + exp_freq;
      end
      if (exp_tlast) begin
        exp_count <= 16'd0;
      end else begin
        exp_count <= exp_count + 16'd1;
      end
    end
  end

  data_check: assert property (@(posedge ce_clk) disable iff (i_reset)
    (o_tvalid && i_tready) |-> (o_tdata == exp_tdata))
    else begin
      errors++;
      $display("Error at %0t: sample data mismatch on transfer %0d", $time, xfers);
    end

  last_check: assert property (@(posedge ce_clk) disable iff (i_reset)
    (o_tvalid && i_tready) |-> (o_tlast == exp_tlast))
    else begin
      errors++;
      $display("Error at %0t: tlast mismatch on transfer %0d", $time, xfers);
    end

  // Offered sample held until taken
  hold_check: assert property (@(posedge ce_clk) disable iff (i_reset)
    (o_tvalid && !i_tready) |=> (o_tvalid && $stable(o_tdata) && $stable(o_tlast)))
    else begin
      errors++;
      $display("Error at %0t: stalled sample changed before transfer", $time);
    end

  idle_valid_check: assert property (@(posedge ce_clk) disable iff (i_reset)
    idle_check |-> !o_tvalid)
    else begin
      errors++;
      $display("Error at %0t: o_tvalid high while disabled", $time);
    end

  task automatic report_totals();
    $display("Summary: %0d check errors, %0d bus hangs, %0d transfers", errors, hangs, xfers);
  endtask

  always @(posedge ce_clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
      report_totals();
      $display("RESULT: FAIL");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Wishbone classic master
  ////////////////////////////////////////
  task automatic wb_access(input logic we, input siggen_regs_pkg::reg_addr_e adr,
                           input logic [31:0] wdat, output logic [31:0] rdat);
    int waits;
    waits = 0;
    rdat  = 32'd0;
    @(posedge ce_clk);
    i_wb_cyc <= 1'b1;
    i_wb_stb <= 1'b1;
    i_wb_we  <= we;
    i_wb_adr <= adr;
    i_wb_dat <= wdat;
    @(posedge ce_clk);
    while (!o_wb_ack && waits < BUS_LIMIT) begin
      @(posedge ce_clk);
      waits++;
    end
    if (o_wb_ack) begin
      rdat = o_wb_dat;
    end else begin
      hangs++;
      $display("Bus hung: no ack from register %0d within %0d cycles", adr, BUS_LIMIT);
    end
    i_wb_cyc <= 1'b0;
    i_wb_stb <= 1'b0;
    i_wb_we  <= 1'b0;
  endtask

  task automatic wb_write(input siggen_regs_pkg::reg_addr_e adr, input logic [31:0] dat);
    logic [31:0] unused_rd;
    wb_access(1'b1, adr, dat, unused_rd);
  endtask

  task automatic check_reg(input siggen_regs_pkg::reg_addr_e adr, input logic [31:0] expected);
    logic [31:0] value;
    wb_access(1'b0, adr, 32'd0, value);
    assert (value == expected) else begin
      errors++;
      $display("Error at %0t: register %0d read %h, expected %h", $time, adr, value, expected);
    end
  endtask

  // Program a stream while disabled and then clear it
  task automatic setup_stream(input siggen_regs_pkg::wave_e wave, input logic [31:0] amp,
                              input logic [31:0] freq, input logic [15:0] pkt);
    wb_write(siggen_regs_pkg::ADDR_WAVEFORM, 32'(wave));
    wb_write(siggen_regs_pkg::ADDR_AMPLITUDE, amp);
    wb_write(siggen_regs_pkg::ADDR_FREQ, freq);
    wb_write(siggen_regs_pkg::ADDR_PKT_SIZE, {16'd0, pkt});
    // Zeroes phase and count and reloads the constant sample
    wb_write(siggen_regs_pkg::ADDR_CLEAR, 32'd1);
    exp_wave  <= wave;
    exp_amp   <= amp;
    exp_freq  <= freq;
    exp_pkt   <= pkt;
    exp_phase <= 32'd0;
    exp_count <= 16'd0;
  endtask

  // Wait for n transfers with optional random back-pressure
  task automatic stream_run(input int n, input logic random_ready);
    int          target;
    logic [31:0] rnd;
    target = xfers + n;
    while (xfers < target) begin
      @(posedge ce_clk);
      rnd = $random(seed);
      i_tready <= random_ready ? rnd[0] : 1'b1;
    end
    @(posedge ce_clk);
    i_tready <= 1'b1;
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////
  initial begin
    seed       = 48441;
    i_reset    = 1'b1;
    i_wb_cyc   = 1'b0;
    i_wb_stb   = 1'b0;
    i_wb_we    = 1'b0;
    i_wb_adr   = 4'd0;
    i_wb_dat   = 32'd0;
    i_tready   = 1'b1;
    idle_check = 1'b0;
    exp_wave   = siggen_regs_pkg::WAVE_CONST;
    exp_amp    = siggen_regs_pkg::AMPLITUDE_RESET;
    exp_freq   = 32'd0;
    exp_phase  = 32'd0;
    exp_pkt    = siggen_regs_pkg::PKT_SIZE_RESET;
    exp_count  = 16'd0;
    repeat (4) @(posedge ce_clk);
    i_reset <= 1'b0;

    // Reset values and readback of written values
    check_reg(siggen_regs_pkg::ADDR_WAVEFORM, 32'(siggen_regs_pkg::WAVE_CONST));
    check_reg(siggen_regs_pkg::ADDR_ENABLE, 32'd0);
    check_reg(siggen_regs_pkg::ADDR_AMPLITUDE, siggen_regs_pkg::AMPLITUDE_RESET);
    check_reg(siggen_regs_pkg::ADDR_FREQ, 32'd0);
    check_reg(siggen_regs_pkg::ADDR_PKT_SIZE, {16'd0, siggen_regs_pkg::PKT_SIZE_RESET});
    check_reg(siggen_regs_pkg::ADDR_CLEAR, 32'd0);
    setup_stream(siggen_regs_pkg::WAVE_SINE, 32'hA5A5_0F0F, 32'h0123_4567, 16'd5);
    check_reg(siggen_regs_pkg::ADDR_WAVEFORM, 32'(siggen_regs_pkg::WAVE_SINE));
    check_reg(siggen_regs_pkg::ADDR_AMPLITUDE, 32'hA5A5_0F0F);
    check_reg(siggen_regs_pkg::ADDR_FREQ, 32'h0123_4567);
    check_reg(siggen_regs_pkg::ADDR_PKT_SIZE, 32'd5);
    check_reg(siggen_regs_pkg::ADDR_CLEAR, 32'd0);

    // Constant waveform with two amplitudes and packet sizes 4 and 1
    setup_stream(siggen_regs_pkg::WAVE_CONST, 32'h1234_5678, 32'd0, 16'd4);
    wb_write(siggen_regs_pkg::ADDR_ENABLE, 32'd1);
    check_reg(siggen_regs_pkg::ADDR_ENABLE, 32'd1);
    stream_run(40, 1'b0);
    wb_write(siggen_regs_pkg::ADDR_ENABLE, 32'd0);
    setup_stream(siggen_regs_pkg::WAVE_CONST, 32'hFEDC_0123, 32'd0, 16'd1);
    wb_write(siggen_regs_pkg::ADDR_ENABLE, 32'd1);
    stream_run(30, 1'b1);
    wb_write(siggen_regs_pkg::ADDR_ENABLE, 32'd0);

    // Sine tone followed by random back-pressure
    setup_stream(siggen_regs_pkg::WAVE_SINE, 32'd0, 32'h0312_3456, 16'd10);
    wb_write(siggen_regs_pkg::ADDR_ENABLE, 32'd1);
    stream_run(100, 1'b0);
    stream_run(200, 1'b1);

    // Idle window and resume from the held phase
    wb_write(siggen_regs_pkg::ADDR_ENABLE, 32'd0);
    idle_check <= 1'b1;
    repeat (50) @(posedge ce_clk);
    idle_check <= 1'b0;
    wb_write(siggen_regs_pkg::ADDR_ENABLE, 32'd1);
    stream_run(60, 1'b1);
    wb_write(siggen_regs_pkg::ADDR_ENABLE, 32'd0);
    repeat (4) @(posedge ce_clk);

    report_totals();
    if (errors == 0 && hangs == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* verilog.f */
verilog/siggen_regs_pkg.sv
verilog/siggen_stream_pkg.sv
verilog/sample_stream_if.sv
verilog/siggen_settings.sv
verilog/sine_tone.sv
verilog/const_source.sv
verilog/packet_framer.sv
verilog/siggen_top.sv
tests/tb_siggen.sv

/* verilog/const_source.sv */
////////////////////////////////////////
// Constant source
// Repeats the programmed amplitude sample
////////////////////////////////////////
`timescale 1ns/100ps

module const_source (
  input  logic                                   ce_clk,
  input  logic                                   i_reset,
  input  logic                                   i_clear,
  input  logic [siggen_stream_pkg::SAMPLE_W-1:0] i_amplitude,
  sample_stream_if.source                        o_stream
);

  logic [siggen_stream_pkg::SAMPLE_W-1:0] amp_q;
  logic                                   valid_q;
  logic                                   xfer;

  assign xfer = valid_q && o_stream.tready;

  // New amplitude only picked up once the current sample is taken
  always_ff @(posedge ce_clk) begin
    if (i_reset || i_clear || xfer) begin
      amp_q <= i_amplitude;
    end
  end

  always_ff @(posedge ce_clk) begin
    if (i_reset) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= 1'b1;
    end
  end

  assign o_stream.tdata  = amp_q;
  assign o_stream.tvalid = valid_q;
  assign o_stream.tlast  = 1'b0;

endmodule

/* verilog/packet_framer.sv */
////////////////////////////////////////
// Packet framer
// Counts transfers and flags the last sample of each packet
////////////////////////////////////////
`timescale 1ns/100ps

module packet_framer (
  input  logic                                    ce_clk,
  input  logic                                    i_reset,
  input  logic                                    i_clear,
  input  logic [siggen_stream_pkg::PKT_LEN_W-1:0] i_pkt_size,
  sample_stream_if.sink                           i_stream,
  sample_stream_if.source                         o_stream
);

  logic [siggen_stream_pkg::PKT_LEN_W-1:0] pkt_len;
  logic [siggen_stream_pkg::PKT_LEN_W-1:0] count;
  logic                                    last_beat;
  logic                                    tlast_out;
  logic                                    xfer;

  // Zero length behaves as one sample per packet
  assign pkt_len = (i_pkt_size == '0) ?
                   {{(siggen_stream_pkg::PKT_LEN_W-1){1'b0}}, 1'b1} : i_pkt_size;

  // Greater-or-equal so a shrunk size still ends the packet
  assign last_beat = (count >= pkt_len - 1'b1);
  assign tlast_out = last_beat || i_stream.tlast;

  assign xfer = i_stream.tvalid && o_stream.tready;

  ////////////////////////////////////////
  // Sample counter
  ////////////////////////////////////////
  always_ff @(posedge ce_clk) begin
    if (i_reset || i_clear) begin
      count <= '0;
    end else if (xfer) begin
      if (tlast_out) begin
        count <= '0;
      end else begin
        count <= count + 1'b1;
      end
    end
  end

  // Pass-through handshake and data
  assign o_stream.tdata  = i_stream.tdata;
  assign o_stream.tvalid = i_stream.tvalid;
  assign o_stream.tlast  = tlast_out;
  assign i_stream.tready = o_stream.tready;

  // Count in range unless the size was just reprogrammed
  a_count_range: assert property (@(posedge ce_clk) disable iff (i_reset)
    (count < pkt_len) |=> ((count < pkt_len) || $changed(i_pkt_size)));

endmodule

/* verilog/sample_stream_if.sv */
////////////////////////////////////////
// Complex sample stream
// Valid/ready handshake with end of packet flag
////////////////////////////////////////
`timescale 1ns/100ps

interface sample_stream_if;

  logic [siggen_stream_pkg::SAMPLE_W-1:0] tdata;
  logic                                   tlast;
  logic                                   tvalid;
  logic                                   tready;

  // Producer side
  modport source (
    output tdata, tlast, tvalid,
    input  tready
  );

  // Consumer side
  modport sink (
    input  tdata, tlast, tvalid,
    output tready
  );

endinterface

/* verilog/siggen_regs_pkg.sv */
////////////////////////////////////////
// Signal generator host register map
// Word addresses, field encodings and reset values
////////////////////////////////////////
package siggen_regs_pkg;

  // Wishbone bus widths
  localparam int WB_ADR_W = 4;
  localparam int WB_DAT_W = 32;

  ////////////////////////////////////////
  // Register word addresses
  ////////////////////////////////////////
  typedef enum logic [WB_ADR_W-1:0] {
    ADDR_WAVEFORM  = 4'd0,
    ADDR_ENABLE    = 4'd1,
    ADDR_AMPLITUDE = 4'd2,
    ADDR_FREQ      = 4'd3,
    ADDR_PKT_SIZE  = 4'd4,
    // Write only, reads back as zero
    ADDR_CLEAR     = 4'd5
  } reg_addr_e;

  // Waveform select field
  typedef enum logic [0:0] {
    WAVE_CONST = 1'b0,
    WAVE_SINE  = 1'b1
  } wave_e;

  ////////////////////////////////////////
  // Reset values
  ////////////////////////////////////////
  localparam wave_e       WAVE_RESET      = WAVE_CONST;
  localparam logic        ENABLE_RESET    = 1'b0;
  localparam logic [31:0] AMPLITUDE_RESET = 32'd0;
  localparam logic [31:0] FREQ_RESET      = 32'd0;
  // Samples per packet
  localparam logic [15:0] PKT_SIZE_RESET  = 16'd16;

endpackage

/* verilog/siggen_settings.sv */
////////////////////////////////////////
// Signal generator settings
// Wishbone classic slave with register file,
// readback and clear pulse
////////////////////////////////////////
`timescale 1ns/100ps

module siggen_settings (
  input  logic                                    ce_clk,
  input  logic                                    i_reset,
  input  logic                                    i_wb_cyc,
  input  logic                                    i_wb_stb,
  input  logic                                    i_wb_we,
  input  logic [siggen_regs_pkg::WB_ADR_W-1:0]    i_wb_adr,
  input  logic [siggen_regs_pkg::WB_DAT_W-1:0]    i_wb_dat,
  output logic [siggen_regs_pkg::WB_DAT_W-1:0]    o_wb_dat,
  output logic                                    o_wb_ack,
  output siggen_regs_pkg::wave_e                  o_wave,
  output logic                                    o_enable,
  output logic [siggen_stream_pkg::SAMPLE_W-1:0]  o_amplitude,
  output logic [siggen_stream_pkg::PHASE_W-1:0]   o_freq,
  output logic [siggen_stream_pkg::PKT_LEN_W-1:0] o_pkt_size,
  output logic                                    o_clear
);

  siggen_regs_pkg::reg_addr_e              addr;
  logic                                    wb_req;
  logic                                    wb_wr;
  logic [siggen_regs_pkg::WB_DAT_W-1:0]    rd_data;

  assign addr = siggen_regs_pkg::reg_addr_e'(i_wb_adr);

  // New access, not yet acknowledged
  assign wb_req = i_wb_cyc && i_wb_stb && !o_wb_ack;
  assign wb_wr  = wb_req && i_wb_we;

  ////////////////////////////////////////
  // Register file
  ////////////////////////////////////////
  always_ff @(posedge ce_clk) begin
    if (i_reset) begin
      o_wb_ack    <= 1'b0;
      o_wave      <= siggen_regs_pkg::WAVE_RESET;
      o_enable    <= siggen_regs_pkg::ENABLE_RESET;
      o_amplitude <= siggen_regs_pkg::AMPLITUDE_RESET;
      o_freq      <= siggen_regs_pkg::FREQ_RESET;
      o_pkt_size  <= siggen_regs_pkg::PKT_SIZE_RESET;
      o_clear     <= 1'b0;
    end else begin
      o_wb_ack <= wb_req;
      o_clear  <= 1'b0;
      if (wb_wr) begin
        case (addr)
          siggen_regs_pkg::ADDR_WAVEFORM:  o_wave <= siggen_regs_pkg::wave_e'(i_wb_dat[0]);
          siggen_regs_pkg::ADDR_ENABLE:    o_enable <= i_wb_dat[0];
          siggen_regs_pkg::ADDR_AMPLITUDE: o_amplitude <= i_wb_dat;
          siggen_regs_pkg::ADDR_FREQ:      o_freq <= i_wb_dat;
          siggen_regs_pkg::ADDR_PKT_SIZE:
            o_pkt_size <= i_wb_dat[siggen_stream_pkg::PKT_LEN_W-1:0];
          siggen_regs_pkg::ADDR_CLEAR:     o_clear <= 1'b1;
          default: ;
        endcase
      end
    end
  end

  // Readback mux
  always_comb begin
    rd_data = '0;
    case (addr)
      siggen_regs_pkg::ADDR_WAVEFORM:  rd_data[0] = o_wave;
      siggen_regs_pkg::ADDR_ENABLE:    rd_data[0] = o_enable;
      siggen_regs_pkg::ADDR_AMPLITUDE: rd_data = o_amplitude;
      siggen_regs_pkg::ADDR_FREQ:      rd_data = o_freq;
      siggen_regs_pkg::ADDR_PKT_SIZE:
        rd_data[siggen_stream_pkg::PKT_LEN_W-1:0] = o_pkt_size;
      default:                         rd_data = '0;
    endcase
  end

  always_ff @(posedge ce_clk) begin
    if (wb_req) begin
      o_wb_dat <= rd_data;
    end
  end

  // Single cycle ack per access
  a_ack_single: assert property (@(posedge ce_clk) disable iff (i_reset)
    o_wb_ack |=> !o_wb_ack);

  // Clear is a one cycle strobe
  a_clear_pulse: assert property (@(posedge ce_clk) disable iff (i_reset)
    o_clear |=> !o_clear);

endmodule

/* verilog/siggen_stream_pkg.sv */
////////////////////////////////////////
// Sample stream format
// Component widths, phase width and sine table
////////////////////////////////////////
package siggen_stream_pkg;

  // Complex sample, I in the upper half and Q in the lower
  localparam int SAMPLE_W = 32;
  localparam int COMP_W   = 16;

  // Phase accumulator and frequency word
  localparam int PHASE_W = 32;

  // Packet length field
  localparam int PKT_LEN_W = 16;

  ////////////////////////////////////////
  // Sine lookup table
  ////////////////////////////////////////
  localparam int TABLE_BITS  = 6;
  localparam int TABLE_DEPTH = 1 << TABLE_BITS;

  // Quarter turn, cosine index from sine index
  localparam logic [TABLE_BITS-1:0] COS_OFFSET = 6'd16;

  // One full period, round(32767 * sin(2*pi*k/64))
  localparam logic signed [COMP_W-1:0] SINE_TABLE [TABLE_DEPTH] = '{
         0,   3212,   6393,   9512,  12539,  15446,  18204,  20787,
     23170,  25329,  27245,  28898,  30273,  31356,  32137,  32609,
     32767,  32609,  32137,  31356,  30273,  28898,  27245,  25329,
     23170,  20787,  18204,  15446,  12539,   9512,   6393,   3212,
         0,  -3212,  -6393,  -9512, -12539, -15446, -18204, -20787,
    -23170, -25329, -27245, -28898, -30273, -31356, -32137, -32609,
    -32767, -32609, -32137, -31356, -30273, -28898, -27245, -25329,
    -23170, -20787, -18204, -15446, -12539,  -9512,  -6393,  -3212
  };

endpackage

/* verilog/siggen_top.sv */
////////////////////////////////////////
// Signal generator top level
// Settings, sources, waveform select and packet framer
////////////////////////////////////////
`timescale 1ns/100ps

module siggen_top (
  input  logic                                   ce_clk,
  input  logic                                   i_reset,
  // Host bus
  input  logic                                   i_wb_cyc,
  input  logic                                   i_wb_stb,
  input  logic                                   i_wb_we,
  input  logic [siggen_regs_pkg::WB_ADR_W-1:0]   i_wb_adr,
  input  logic [siggen_regs_pkg::WB_DAT_W-1:0]   i_wb_dat,
  output logic [siggen_regs_pkg::WB_DAT_W-1:0]   o_wb_dat,
  output logic                                   o_wb_ack,
  // Output sample stream
  output logic [siggen_stream_pkg::SAMPLE_W-1:0] o_tdata,
  output logic                                   o_tlast,
  output logic                                   o_tvalid,
  input  logic                                   i_tready
);

  siggen_regs_pkg::wave_e                  wave;
  logic                                    enable;
  logic [siggen_stream_pkg::SAMPLE_W-1:0]  amplitude;
  logic [siggen_stream_pkg::PHASE_W-1:0]   freq;
  logic [siggen_stream_pkg::PKT_LEN_W-1:0] pkt_size;
  logic                                    clear;
  logic                                    sel_sine;

  sample_stream_if sine_if ();
  sample_stream_if const_if ();
  sample_stream_if sel_if ();
  sample_stream_if framed_if ();

  siggen_settings u_settings (
    .ce_clk      (ce_clk),
    .i_reset     (i_reset),
    .i_wb_cyc    (i_wb_cyc),
    .i_wb_stb    (i_wb_stb),
    .i_wb_we     (i_wb_we),
    .i_wb_adr    (i_wb_adr),
    .i_wb_dat    (i_wb_dat),
    .o_wb_dat    (o_wb_dat),
    .o_wb_ack    (o_wb_ack),
    .o_wave      (wave),
    .o_enable    (enable),
    .o_amplitude (amplitude),
    .o_freq      (freq),
    .o_pkt_size  (pkt_size),
    .o_clear     (clear)
  );

  sine_tone u_sine (
    .ce_clk   (ce_clk),
    .i_reset  (i_reset),
    .i_clear  (clear),
    .i_freq   (freq),
    .o_stream (sine_if.source)
  );

  const_source u_const (
    .ce_clk      (ce_clk),
    .i_reset     (i_reset),
    .i_clear     (clear),
    .i_amplitude (amplitude),
    .o_stream    (const_if.source)
  );

  ////////////////////////////////////////
  // Waveform select and enable gating
  ////////////////////////////////////////
  assign sel_sine = (wave == siggen_regs_pkg::WAVE_SINE);

  assign sel_if.tdata  = sel_sine ? sine_if.tdata : const_if.tdata;
  assign sel_if.tlast  = sel_sine ? sine_if.tlast : const_if.tlast;
  assign sel_if.tvalid = (sel_sine ? sine_if.tvalid : const_if.tvalid) && enable;

  // Unselected source stalls
  assign sine_if.tready  = sel_sine && enable && sel_if.tready;
  assign const_if.tready = !sel_sine && enable && sel_if.tready;

  packet_framer u_framer (
    .ce_clk     (ce_clk),
    .i_reset    (i_reset),
    .i_clear    (clear),
    .i_pkt_size (pkt_size),
    .i_stream   (sel_if.sink),
    .o_stream   (framed_if.source)
  );

  assign o_tdata          = framed_if.tdata;
  assign o_tlast          = framed_if.tlast;
  assign o_tvalid         = framed_if.tvalid;
  assign framed_if.tready = i_tready;

endmodule

/* verilog/sine_tone.sv */
////////////////////////////////////////
// Sine tone source
// Phase accumulator and table lookup, {cos, sin} samples
////////////////////////////////////////
`timescale 1ns/100ps

module sine_tone (
  input  logic                                  ce_clk,
  input  logic                                  i_reset,
  input  logic                                  i_clear,
  input  logic [siggen_stream_pkg::PHASE_W-1:0] i_freq,
  sample_stream_if.source                       o_stream
);

  logic [siggen_stream_pkg::PHASE_W-1:0]  phase;
  logic [siggen_stream_pkg::PHASE_W-1:0]  next_phase;
  logic [siggen_stream_pkg::SAMPLE_W-1:0] sample_q;
  logic                                   valid_q;
  logic                                   xfer;

  // Table lookup from the top bits of the phase
  function automatic logic [siggen_stream_pkg::SAMPLE_W-1:0] lookup(
    input logic [siggen_stream_pkg::PHASE_W-1:0] ph
  );
    logic [siggen_stream_pkg::TABLE_BITS-1:0] sin_idx;
    logic [siggen_stream_pkg::TABLE_BITS-1:0] cos_idx;
    sin_idx = ph[siggen_stream_pkg::PHASE_W-1 -: siggen_stream_pkg::TABLE_BITS];
    // Index wraps modulo table depth
    cos_idx = sin_idx + siggen_stream_pkg::COS_OFFSET;
    return {siggen_stream_pkg::SINE_TABLE[cos_idx], siggen_stream_pkg::SINE_TABLE[sin_idx]};
  endfunction

  assign xfer       = valid_q && o_stream.tready;
  assign next_phase = phase + i_freq;

  ////////////////////////////////////////
  // Phase and output register
  ////////////////////////////////////////
  always_ff @(posedge ce_clk) begin
    if (i_reset || i_clear) begin
      phase    <= '0;
      sample_q <= lookup('0);
    end else if (xfer) begin
      phase    <= next_phase;
      sample_q <= lookup(next_phase);
    end
  end

  // Sample offered from the cycle after reset
  always_ff @(posedge ce_clk) begin
    if (i_reset) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= 1'b1;
    end
  end

  assign o_stream.tdata  = sample_q;
  assign o_stream.tvalid = valid_q;
  assign o_stream.tlast  = 1'b0;

  // Held sample does not change under back-pressure
  a_hold_data: assert property (@(posedge ce_clk) disable iff (i_reset)
    (o_stream.tvalid && !o_stream.tready && !i_clear) |=> $stable(o_stream.tdata));

endmodule
